//--- cheat_pkg.sv
package cheat_pkg;

  // Console bus and APB widths
  localparam int BUS_ADDR_W = 24;
  localparam int BUS_DATA_W = 8;
  localparam int APB_ADDR_W = 8;

  ////////////////////////////////////////
  // APB register map
  ////////////////////////////////////////
  // Slot n sits at REG_SLOT_BASE + 4*n
  localparam logic [APB_ADDR_W-1:0] REG_SLOT_BASE = 8'h00;
  localparam logic [APB_ADDR_W-1:0] REG_MASK      = 8'h18;
  localparam logic [APB_ADDR_W-1:0] REG_CTRL      = 8'h1C;
  localparam logic [APB_ADDR_W-1:0] REG_STATUS    = 8'h20;

  // Program word, read as a slot entry or as control set/clear flags
  typedef union packed {
    struct packed {
      logic [BUS_ADDR_W-1:0] addr;
      logic [BUS_DATA_W-1:0] data;
    } slot;
    struct packed {
      logic [24:0] spare_hi;
      logic [2:0]  clr;       // irq, nmi, cheat
      logic        spare_lo;
      logic [2:0]  set;       // irq, nmi, cheat
    } ctrl;
  } pgm_word_u;

  ////////////////////////////////////////
  // Vectors and substituted bytes
  ////////////////////////////////////////
  localparam logic [BUS_ADDR_W-1:0] NMI_VEC_LO = 24'h00FFEA;
  localparam logic [BUS_ADDR_W-1:0] NMI_VEC_HI = 24'h00FFEB;
  localparam logic [BUS_ADDR_W-1:0] IRQ_VEC_LO = 24'h00FFEE;
  localparam logic [BUS_ADDR_W-1:0] IRQ_VEC_HI = 24'h00FFEF;

  localparam logic [BUS_DATA_W-1:0] NMI_HOOK_BYTE = 8'h12;
  localparam logic [BUS_DATA_W-1:0] IRQ_HOOK_BYTE = 8'h18;
  localparam logic [BUS_DATA_W-1:0] DEFAULT_BYTE  = 8'h2A;

  // Console command window, matched on the low address byte
  localparam logic [7:0] CMD_OFFSET     = 8'h00;
  localparam logic [7:0] DISABLE_OFFSET = 8'hBD;

  localparam logic [BUS_DATA_W-1:0] CMD_CHEAT_ON  = 8'h82;
  localparam logic [BUS_DATA_W-1:0] CMD_CHEAT_OFF = 8'h83;
  localparam logic [BUS_DATA_W-1:0] CMD_HOOKS_OFF = 8'h84;
  localparam logic [BUS_DATA_W-1:0] CMD_HOLDOFF   = 8'h85;

  typedef enum logic [1:0] {
    VEC_NONE = 2'd0,
    VEC_NMI  = 2'd1,
    VEC_IRQ  = 2'd2
  } vec_sel_e;

endpackage

//--- cheat_bus_if.sv
`timescale 1ns/1ps

interface cheat_bus_if;

  // Observed console bus
  logic [cheat_pkg::BUS_ADDR_W-1:0] bus_addr;
  logic [cheat_pkg::BUS_DATA_W-1:0] bus_data;
  logic                             cmd_wr;
  logic                             cycle_start;

  // Driven from the top-level pins
  modport mon (
    output bus_addr, bus_data, cmd_wr, cycle_start
  );

  modport regs (
    input cmd_wr, bus_addr, bus_data
  );

  modport match (
    input bus_addr
  );

  modport hook (
    input bus_addr, cycle_start
  );

endinterface

//--- cheat_cfg_if.sv
`timescale 1ns/1ps

interface cheat_cfg_if #(
  parameter int NUM_SLOTS = 6
);

  // Patch slot table
  logic [cheat_pkg::BUS_ADDR_W-1:0] slot_addr [NUM_SLOTS];
  logic [cheat_pkg::BUS_DATA_W-1:0] slot_data [NUM_SLOTS];
  logic [NUM_SLOTS-1:0]             slot_mask;

  // Global enables
  logic cheat_enable;
  logic nmi_enable;
  logic irq_enable;

  // Hook gating, hook_enable already folds in the holdoff counter
  logic hook_enable;
  logic hook_disable;

  modport src (
    output slot_addr, slot_data, slot_mask,
    output cheat_enable, nmi_enable, irq_enable,
    output hook_enable, hook_disable
  );

  modport patch (
    input slot_addr, slot_data, slot_mask, cheat_enable
  );

  modport hook (
    input nmi_enable, irq_enable, hook_enable, hook_disable
  );

endinterface

//--- cheat_apb_regs.sv
`timescale 1ns/1ps

module cheat_apb_regs #(
  parameter int          NUM_SLOTS    = 6,
  parameter int unsigned HOOK_HOLDOFF = 880000000
) (
  input  logic                            clk,
  input  logic                            arst_n,
  input  logic                            psel,
  input  logic                            penable,
  input  logic                            pwrite,
  input  logic [cheat_pkg::APB_ADDR_W-1:0] paddr,
  input  logic [31:0]                     pwdata,
  input  logic                            auto_nmi,
  input  logic                            auto_irq,
  output logic [31:0]                     prdata,
  output logic                            pready,
  output logic                            pslverr,
  cheat_bus_if.regs                       bus,
  cheat_cfg_if.src                        cfg
);

  localparam int AW     = cheat_pkg::APB_ADDR_W;
  localparam int HOLD_W = (HOOK_HOLDOFF > 0) ? $clog2(HOOK_HOLDOFF + 1) : 1;

  logic [cheat_pkg::BUS_ADDR_W-1:0] slot_addr [NUM_SLOTS];
  logic [cheat_pkg::BUS_DATA_W-1:0] slot_data [NUM_SLOTS];
  logic [NUM_SLOTS-1:0]             slot_mask;
  logic [2:0]                       flags;       // irq, nmi, cheat
  logic                             hook_disable;
  logic [HOLD_W-1:0]                holdoff_cnt;

  logic                 access;
  logic                 apb_wr;
  logic [NUM_SLOTS-1:0] slot_sel;
  logic                 mask_hit;
  logic                 ctrl_hit;
  logic                 status_hit;
  logic                 addr_ok;
  cheat_pkg::pgm_word_u wr_word;
  cheat_pkg::pgm_word_u rd_word;

  ////////////////////////////////////////
  // APB decode
  ////////////////////////////////////////
  // Console command cycles stall the access phase for one cycle
  assign pready = ~bus.cmd_wr;
  assign access = psel & penable;
  assign apb_wr = access & pwrite & pready;

  always_comb begin
    for (int i = 0; i < NUM_SLOTS; i++) begin
      slot_sel[i] = (paddr == cheat_pkg::REG_SLOT_BASE + AW'(4 * i));
    end
  end

  assign mask_hit   = (paddr == cheat_pkg::REG_MASK);
  assign ctrl_hit   = (paddr == cheat_pkg::REG_CTRL);
  assign status_hit = (paddr == cheat_pkg::REG_STATUS);
  assign addr_ok    = (|slot_sel) | mask_hit | ctrl_hit | status_hit;

  assign pslverr = access & pready & (~addr_ok | (pwrite & status_hit));
  assign wr_word = pwdata;

  // Read data, valid during the access cycle
  always_comb begin
    rd_word = '0;
    if (access && !pwrite) begin
      for (int i = 0; i < NUM_SLOTS; i++) begin
        if (slot_sel[i]) begin
          rd_word.slot.addr = slot_addr[i];
          rd_word.slot.data = slot_data[i];
        end
      end
      if (mask_hit) rd_word = 32'(slot_mask);
      if (ctrl_hit) rd_word.ctrl.set = flags;
      if (status_hit) rd_word = 32'({hook_disable, cfg.hook_enable, auto_irq, auto_nmi});
    end
  end

  assign prdata = rd_word;

  // Slot table
  always_ff @(posedge clk) begin
    for (int i = 0; i < NUM_SLOTS; i++) begin
      if (apb_wr && slot_sel[i]) begin
        slot_addr[i] <= wr_word.slot.addr;
        slot_data[i] <= wr_word.slot.data;
      end
    end
  end

  ////////////////////////////////////////
  // Control state and console commands
  ////////////////////////////////////////
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      slot_mask    <= '0;
      flags        <= '0;
      hook_disable <= 1'b0;
      holdoff_cnt  <= '0;
    end else if (bus.cmd_wr) begin
      if (bus.bus_addr[7:0] == cheat_pkg::CMD_OFFSET) begin
        case (bus.bus_data)
          cheat_pkg::CMD_CHEAT_ON:  flags[0] <= 1'b1;
          cheat_pkg::CMD_CHEAT_OFF: flags[0] <= 1'b0;
          cheat_pkg::CMD_HOOKS_OFF: flags[2:1] <= 2'b00;
          cheat_pkg::CMD_HOLDOFF:   holdoff_cnt <= HOLD_W'(HOOK_HOLDOFF);
          default: ;
        endcase
      end else if (bus.bus_addr[7:0] == cheat_pkg::DISABLE_OFFSET) begin
        hook_disable <= bus.bus_data[0];
      end
    end else if (apb_wr) begin
      if (mask_hit) slot_mask <= pwdata[NUM_SLOTS-1:0];
      // Set wins over clear
      if (ctrl_hit) flags <= (flags & ~wr_word.ctrl.clr) | wr_word.ctrl.set;
    end else if (|holdoff_cnt) begin
      holdoff_cnt <= holdoff_cnt - 1'b1;
    end
  end

  assign cfg.slot_addr    = slot_addr;
  assign cfg.slot_data    = slot_data;
  assign cfg.slot_mask    = slot_mask;
  assign cfg.cheat_enable = flags[0];
  assign cfg.nmi_enable   = flags[1];
  assign cfg.irq_enable   = flags[2];
  assign cfg.hook_disable = hook_disable;
  assign cfg.hook_enable  = ~|holdoff_cnt & ~hook_disable;

endmodule

//--- cheat_patch_match.sv
`timescale 1ns/1ps

module cheat_patch_match #(
  parameter int NUM_SLOTS = 6
) (
  cheat_bus_if.match                      bus,
  cheat_cfg_if.patch                      cfg,
  output logic                            patch_match,
  output logic [cheat_pkg::BUS_DATA_W-1:0] patch_data,
  output logic                            patch_hit
);

  logic [NUM_SLOTS-1:0] match_bits;

  // One comparator per slot, gated by its mask bit
  for (genvar i = 0; i < NUM_SLOTS; i++) begin : g_cmp
    assign match_bits[i] = cfg.slot_mask[i] & (bus.bus_addr == cfg.slot_addr[i]);
  end

  assign patch_match = |match_bits;

  // Lowest slot number wins, so scan from the top down
  always_comb begin
    patch_data = '0;
    for (int i = NUM_SLOTS - 1; i >= 0; i--) begin
      if (match_bits[i]) begin
        patch_data = cfg.slot_data[i];
      end
    end
  end

  // Data still shows without cheat_enable, only the hit is gated
  assign patch_hit = patch_match & cfg.cheat_enable;

endmodule

//--- hook_autoselect.sv
`timescale 1ns/1ps

module hook_autoselect #(
  parameter int USAGE_CNT_W = 21
) (
  input  logic                clk,
  input  logic                arst_n,
  cheat_bus_if.hook           bus,
  cheat_cfg_if.hook           cfg,
  output cheat_pkg::vec_sel_e vec_sel,
  output logic                hook_hit,
  output logic                auto_nmi,
  output logic                auto_irq
);

  localparam int USE_W = 5;

  logic nmi_lo;
  logic nmi_hi;
  logic irq_lo;
  logic irq_hi;
  logic vec_addr;
  logic nmi_fetch;
  logic irq_fetch;
  logic period_end;
  logic choose_irq;

  logic [USAGE_CNT_W-1:0] usage_cnt;
  logic [USE_W-1:0]       nmi_usage;
  logic [USE_W-1:0]       irq_usage;
  logic [1:0]             sync_delay;
  logic                   auto_nmi_sync;
  logic                   auto_irq_sync;
  logic                   hook_en_sync;

  // Vector address decode
  assign nmi_lo   = (bus.bus_addr == cheat_pkg::NMI_VEC_LO);
  assign nmi_hi   = (bus.bus_addr == cheat_pkg::NMI_VEC_HI);
  assign irq_lo   = (bus.bus_addr == cheat_pkg::IRQ_VEC_LO);
  assign irq_hi   = (bus.bus_addr == cheat_pkg::IRQ_VEC_HI);
  assign vec_addr = nmi_lo | nmi_hi | irq_lo | irq_hi;

  // Only the high byte fetch counts as one vector use
  assign nmi_fetch = bus.cycle_start & nmi_hi & ~cfg.hook_disable;
  assign irq_fetch = bus.cycle_start & irq_hi & ~cfg.hook_disable;

  ////////////////////////////////////////
  // Usage period and choice
  ////////////////////////////////////////
  assign period_end = (usage_cnt == '0);
  // NMI unless only IRQ was seen
  assign choose_irq = (irq_usage != '0) && (nmi_usage == '0);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      usage_cnt <= '1;
      nmi_usage <= '0;
      irq_usage <= '0;
      auto_nmi  <= 1'b1;
      auto_irq  <= 1'b0;
    end else begin
      usage_cnt <= usage_cnt - 1'b1;
      if (period_end) begin
        auto_nmi  <= ~choose_irq;
        auto_irq  <= choose_irq;
        // A fetch in the wrap cycle starts the next period
        nmi_usage <= USE_W'(nmi_fetch);
        irq_usage <= USE_W'(irq_fetch);
      end else begin
        if (nmi_fetch && !(&nmi_usage)) nmi_usage <= nmi_usage + 1'b1;
        if (irq_fetch && !(&irq_usage)) irq_usage <= irq_usage + 1'b1;
      end
    end
  end

  ////////////////////////////////////////
  // Sync, never switch during a vector read
  ////////////////////////////////////////
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      sync_delay    <= 2'd2;
      auto_nmi_sync <= 1'b0;
      auto_irq_sync <= 1'b0;
      hook_en_sync  <= 1'b0;
    end else if (bus.cycle_start) begin
      if (vec_addr) begin
        sync_delay <= 2'd2;
      end else begin
        if (sync_delay != 2'd0) sync_delay <= sync_delay - 1'b1;
        // Second quiet cycle_start onward
        if (sync_delay <= 2'd1) begin
          auto_nmi_sync <= auto_nmi;
          auto_irq_sync <= auto_irq;
          hook_en_sync  <= cfg.hook_enable;
        end
      end
    end
  end

  assign hook_hit = hook_en_sync &
                    ((auto_nmi_sync & cfg.nmi_enable & (nmi_lo | nmi_hi)) |
                     (auto_irq_sync & cfg.irq_enable & (irq_lo | irq_hi)));

  always_comb begin
    if (nmi_lo) vec_sel = cheat_pkg::VEC_NMI;
    else if (irq_lo) vec_sel = cheat_pkg::VEC_IRQ;
    else vec_sel = cheat_pkg::VEC_NONE;
  end

endmodule

//--- cheat_bus_out.sv
`timescale 1ns/1ps

module cheat_bus_out (
  input  logic                             patch_match,
  input  logic [cheat_pkg::BUS_DATA_W-1:0] patch_data,
  input  logic                             patch_hit,
  input  cheat_pkg::vec_sel_e              vec_sel,
  input  logic                             hook_hit,
  output logic [cheat_pkg::BUS_DATA_W-1:0] data_out,
  output logic                             cheat_hit
);

  // Patches override the vector bytes
  always_comb begin
    if (patch_match) begin
      data_out = patch_data;
    end else begin
      case (vec_sel)
        cheat_pkg::VEC_NMI: data_out = cheat_pkg::NMI_HOOK_BYTE;
        cheat_pkg::VEC_IRQ: data_out = cheat_pkg::IRQ_HOOK_BYTE;
        default:            data_out = cheat_pkg::DEFAULT_BYTE;
      endcase
    end
  end

  assign cheat_hit = patch_hit | hook_hit;

endmodule

//--- cheat_top.sv
`timescale 1ns/1ps

module cheat_top #(
  parameter int          NUM_SLOTS    = 6,
  parameter int          USAGE_CNT_W  = 21,
  parameter int unsigned HOOK_HOLDOFF = 880000000
) (
  input  logic                             clk,
  input  logic                             arst_n,
  input  logic                             psel,
  input  logic                             penable,
  input  logic                             pwrite,
  input  logic [cheat_pkg::APB_ADDR_W-1:0] paddr,
  input  logic [31:0]                      pwdata,
  input  logic [cheat_pkg::BUS_ADDR_W-1:0] bus_addr,
  input  logic [cheat_pkg::BUS_DATA_W-1:0] bus_data,
  input  logic                             cmd_wr,
  input  logic                             cycle_start,
  output logic [31:0]                      prdata,
  output logic                             pready,
  output logic                             pslverr,
  output logic [cheat_pkg::BUS_DATA_W-1:0] data_out,
  output logic                             cheat_hit
);

  cheat_bus_if                          bus_if ();
  cheat_cfg_if #(.NUM_SLOTS(NUM_SLOTS)) cfg_if ();

  logic                             auto_nmi;
  logic                             auto_irq;
  logic                             patch_match;
  logic [cheat_pkg::BUS_DATA_W-1:0] patch_data;
  logic                             patch_hit;
  cheat_pkg::vec_sel_e              vec_sel;
  logic                             hook_hit;

  // Console bus pins into the monitor bundle
  assign bus_if.bus_addr    = bus_addr;
  assign bus_if.bus_data    = bus_data;
  assign bus_if.cmd_wr      = cmd_wr;
  assign bus_if.cycle_start = cycle_start;

  cheat_apb_regs #(
    .NUM_SLOTS    (NUM_SLOTS),
    .HOOK_HOLDOFF (HOOK_HOLDOFF)
  ) regs_i (
    .clk      (clk),
    .arst_n   (arst_n),
    .psel     (psel),
    .penable  (penable),
    .pwrite   (pwrite),
    .paddr    (paddr),
    .pwdata   (pwdata),
    .auto_nmi (auto_nmi),
    .auto_irq (auto_irq),
    .prdata   (prdata),
    .pready   (pready),
    .pslverr  (pslverr),
    .bus      (bus_if),
    .cfg      (cfg_if)
  );

  cheat_patch_match #(.NUM_SLOTS(NUM_SLOTS)) match_i (
    .bus         (bus_if),
    .cfg         (cfg_if),
    .patch_match (patch_match),
    .patch_data  (patch_data),
    .patch_hit   (patch_hit)
  );

  hook_autoselect #(.USAGE_CNT_W(USAGE_CNT_W)) hook_i (
    .clk      (clk),
    .arst_n   (arst_n),
    .bus      (bus_if),
    .cfg      (cfg_if),
    .vec_sel  (vec_sel),
    .hook_hit (hook_hit),
    .auto_nmi (auto_nmi),
    .auto_irq (auto_irq)
  );

  cheat_bus_out out_i (
    .patch_match (patch_match),
    .patch_data  (patch_data),
    .patch_hit   (patch_hit),
    .vec_sel     (vec_sel),
    .hook_hit    (hook_hit),
    .data_out    (data_out),
    .cheat_hit   (cheat_hit)
  );

endmodule

//--- cheat_tb_sva.sv
`timescale 1ns/1ps

module cheat_tb_sva (
  input logic                             clk,
  input logic                             arst_n,
  input logic                             psel,
  input logic                             penable,
  input logic                             pwrite,
  input logic [cheat_pkg::APB_ADDR_W-1:0] paddr,
  input logic                             pready,
  input logic                             pslverr,
  input logic [cheat_pkg::BUS_ADDR_W-1:0] bus_addr,
  input logic                             cmd_wr,
  input logic                             cheat_hit
);

  logic ctrl_wr;
  logic en_cmd;
  logic en_written;

  // Enable writes as seen on the pins
  assign ctrl_wr = psel & penable & pwrite & pready & (paddr == cheat_pkg::REG_CTRL);
  assign en_cmd  = cmd_wr & (bus_addr[7:0] == cheat_pkg::CMD_OFFSET);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      en_written <= 1'b0;
    end else if (ctrl_wr || en_cmd) begin
      en_written <= 1'b1;
    end
  end

  // Error response only on a completing access
  a_err_with_ready: assert property (@(posedge clk) disable iff (!arst_n) pslverr |-> pready)
    else $error("pslverr high while pready is low");

  // Console commands are the only source of wait states
  a_stall_on_cmd: assert property (@(posedge clk) disable iff (!arst_n) !pready |-> cmd_wr)
    else $error("pready low in a cycle without cmd_wr");

  // No hit before the first enable write after reset
  a_hit_after_enable: assert property (@(posedge clk) disable iff (!arst_n)
                                       cheat_hit |-> en_written)
    else $error("cheat_hit high before any enable was written");

endmodule

bind cheat_top cheat_tb_sva sva_i (
  .clk       (clk),
  .arst_n    (arst_n),
  .psel      (psel),
  .penable   (penable),
  .pwrite    (pwrite),
  .paddr     (paddr),
  .pready    (pready),
  .pslverr   (pslverr),
  .bus_addr  (bus_addr),
  .cmd_wr    (cmd_wr),
  .cheat_hit (cheat_hit)
);

//--- cheat_tb.sv
`timescale 1ns/1ps

module cheat_tb;

  localparam int NUM_SLOTS    = 6;
  localparam int USAGE_CNT_W  = 8;
  localparam int HOOK_HOLDOFF = 64;
  localparam int CLK_PERIOD   = 100;
  localparam int RESET_CYCLES = 8;

  // Cycle budget of each test
  localparam int T_REGS    = 80;
  localparam int T_PATCH   = 60;
  localparam int T_ENABLE  = 50;
  localparam int T_HOOK    = 40;
  localparam int T_HOLDOFF = 2 * HOOK_HOLDOFF + 60;
  localparam int T_AUTO    = 2 * (2 ** USAGE_CNT_W) + 40;
  localparam int WATCHDOG_CYCLES = RESET_CYCLES + T_REGS + T_PATCH + T_ENABLE + T_HOOK +
                                   T_HOLDOFF + T_AUTO + 300;

  // Never a slot or vector address
  localparam logic [23:0] QUIET_ADDR = 24'h008000;

  logic        clk;
  logic        arst_n;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [7:0]  paddr;
  logic [31:0] pwdata;
  logic [23:0] bus_addr;
  logic [7:0]  bus_data;
  logic        cmd_wr;
  logic        cycle_start;
  logic [31:0] prdata;
  logic        pready;
  logic        pslverr;
  logic [7:0]  data_out;
  logic        cheat_hit;

  logic [15:0] lfsr;
  int          err_cnt;
  int          last_stalls;
  logic [31:0] slot_exp [NUM_SLOTS];
  logic [5:0]  mask_exp;

  cheat_top #(
    .NUM_SLOTS    (NUM_SLOTS),
    .USAGE_CNT_W  (USAGE_CNT_W),
    .HOOK_HOLDOFF (HOOK_HOLDOFF)
  ) dut_i (
    .clk         (clk),
    .arst_n      (arst_n),
    .psel        (psel),
    .penable     (penable),
    .pwrite      (pwrite),
    .paddr       (paddr),
    .pwdata      (pwdata),
    .bus_addr    (bus_addr),
    .bus_data    (bus_data),
    .cmd_wr      (cmd_wr),
    .cycle_start (cycle_start),
    .prdata      (prdata),
    .pready      (pready),
    .pslverr     (pslverr),
    .data_out    (data_out),
    .cheat_hit   (cheat_hit)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////
  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      err_cnt++;
      $display("ERR %s got 0x%0h expected 0x%0h", name, got, exp);
      $display("Simulation FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  // Galois LFSR stepped once per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
    end
    return v;
  endfunction

  // Flag order in each field is irq, nmi, cheat
  function automatic logic [31:0] ctrl_word(input logic [2:0] clr, input logic [2:0] set);
    return {25'd0, clr, 1'b0, set};
  endfunction

  function automatic logic [31:0] status_word(input logic nmi, input logic irq,
                                              input logic hook_en, input logic hook_dis);
    return {28'd0, hook_dis, hook_en, irq, nmi};
  endfunction

  // First enabled slot on the address gives the data
  function automatic logic [8:0] expected_patch(input logic [23:0] addr);
    logic [8:0] res;
    res = {1'b0, cheat_pkg::DEFAULT_BYTE};
    for (int i = 0; i < NUM_SLOTS; i++) begin
      if (!res[8] && mask_exp[i] && slot_exp[i][31:8] == addr) begin
        res = {1'b1, slot_exp[i][7:0]};
      end
    end
    return res;
  endfunction

  task automatic apb_xfer(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                          output logic [31:0] rdata, output logic err);
    int waits;
    waits = 0;
    @(posedge clk);
    #1;
    psel = 1'b1;
    penable = 1'b0;
    pwrite = wr;
    paddr = addr;
    pwdata = wdata;
    @(posedge clk);
    #1;
    penable = 1'b1;
    @(negedge clk);
    while (!pready) begin
      waits++;
      if (waits > 16) begin
        $display("APB transfer at 0x%0h never completed", addr);
        $display("Simulation FAILED");
        $fatal(1, "APB hang");
      end
      @(negedge clk);
    end
    last_stalls = waits;
    rdata = prdata;
    err = pslverr;
    @(posedge clk);
    #1;
    psel = 1'b0;
    penable = 1'b0;
  endtask

  task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
    logic [31:0] rd;
    logic        err;
    apb_xfer(1'b1, addr, data, rd, err);
    check("pslverr", err, 0);
  endtask

  task automatic apb_read(input logic [7:0] addr, input logic [31:0] exp);
    logic [31:0] rd;
    logic        err;
    apb_xfer(1'b0, addr, 32'd0, rd, err);
    check($sformatf("prdata@0x%02h", addr), rd, exp);
    check("pslverr", err, 0);
  endtask

  task automatic console_cmd(input logic [7:0] offset, input logic [7:0] data);
    @(posedge clk);
    #1;
    cmd_wr = 1'b1;
    bus_addr = {16'h2100, offset};
    bus_data = data;
    @(posedge clk);
    #1;
    cmd_wr = 1'b0;
  endtask

  // One bus cycle with cycle_start and an idle cycle
  task automatic fetch(input logic [23:0] addr, input logic [7:0] exp_data, input logic exp_hit);
    @(posedge clk);
    #1;
    bus_addr = addr;
    cycle_start = 1'b1;
    #1;
    check("data_out", data_out, exp_data);
    check("cheat_hit", cheat_hit, exp_hit);
    @(posedge clk);
    #1;
    cycle_start = 1'b0;
  endtask

  task automatic fetch_patch(input logic [23:0] addr, input logic cheat_on);
    logic [8:0] exp;
    exp = expected_patch(addr);
    fetch(addr, exp[7:0], exp[8] & cheat_on);
  endtask

  task automatic quiet_fetches(input int n);
    repeat (n) fetch(QUIET_ADDR, cheat_pkg::DEFAULT_BYTE, 1'b0);
  endtask

  ////////////////////////////////////////
  // Tests
  ////////////////////////////////////////
  task automatic register_access();
    logic [31:0] rnd;
    logic [31:0] rd;
    logic        err;
    apb_read(cheat_pkg::REG_STATUS, status_word(1, 0, 1, 0));
    for (int i = 0; i < NUM_SLOTS; i++) begin
      rnd = rand_bits(24);
      // Top byte fixed so no slot lands on a vector
      slot_exp[i] = {8'h40, rnd[23:0]};
      apb_write(cheat_pkg::REG_SLOT_BASE + 8'(4 * i), slot_exp[i]);
    end
    for (int i = 0; i < NUM_SLOTS; i++) begin
      apb_read(cheat_pkg::REG_SLOT_BASE + 8'(4 * i), slot_exp[i]);
    end
    apb_write(cheat_pkg::REG_MASK, 32'hFFFF_FF15);
    mask_exp = 6'h15;
    apb_read(cheat_pkg::REG_MASK, 32'h15);
    apb_write(cheat_pkg::REG_CTRL, ctrl_word(3'b000, 3'b101));
    apb_read(cheat_pkg::REG_CTRL, 32'h5);
    apb_write(cheat_pkg::REG_CTRL, ctrl_word(3'b111, 3'b000));
    apb_read(cheat_pkg::REG_CTRL, 32'h0);
    apb_xfer(1'b0, 8'h40, 32'd0, rd, err);
    check("pslverr", err, 1);
    apb_xfer(1'b1, cheat_pkg::REG_STATUS, 32'hF, rd, err);
    check("pslverr", err, 1);
  endtask

  task automatic patch_matching();
    apb_write(cheat_pkg::REG_MASK, 32'h3F);
    mask_exp = 6'h3F;
    apb_write(cheat_pkg::REG_CTRL, ctrl_word(3'b000, 3'b001));
    for (int i = 0; i < NUM_SLOTS; i++) fetch_patch(slot_exp[i][31:8], 1'b1);
    // Slot 4 shares the address of slot 1
    slot_exp[4] = {slot_exp[1][31:8], 8'hC3};
    apb_write(cheat_pkg::REG_SLOT_BASE + 8'h10, slot_exp[4]);
    fetch(slot_exp[1][31:8], slot_exp[1][7:0], 1'b1);
    apb_write(cheat_pkg::REG_MASK, 32'h3D);
    mask_exp = 6'h3D;
    fetch(slot_exp[1][31:8], 8'hC3, 1'b1);
    apb_write(cheat_pkg::REG_MASK, 32'h3C);
    mask_exp = 6'h3C;
    fetch_patch(slot_exp[0][31:8], 1'b1);
    // Data without the hit once cheats are off
    apb_write(cheat_pkg::REG_CTRL, ctrl_word(3'b001, 3'b000));
    fetch_patch(slot_exp[2][31:8], 1'b0);
  endtask

  task automatic enable_control();
    console_cmd(cheat_pkg::CMD_OFFSET, cheat_pkg::CMD_CHEAT_ON);
    fetch_patch(slot_exp[2][31:8], 1'b1);
    console_cmd(cheat_pkg::CMD_OFFSET, cheat_pkg::CMD_CHEAT_OFF);
    fetch_patch(slot_exp[2][31:8], 1'b0);
    apb_write(cheat_pkg::REG_CTRL, ctrl_word(3'b111, 3'b111));
    apb_read(cheat_pkg::REG_CTRL, 32'h7);
    apb_write(cheat_pkg::REG_CTRL, ctrl_word(3'b111, 3'b001));
    apb_read(cheat_pkg::REG_CTRL, 32'h1);
    apb_write(cheat_pkg::REG_CTRL, ctrl_word(3'b111, 3'b000));
    // Console command lands in the APB access cycle
    fork
      apb_write(cheat_pkg::REG_MASK, 32'h2A);
      begin
        @(posedge clk);
        console_cmd(cheat_pkg::CMD_OFFSET, cheat_pkg::CMD_CHEAT_ON);
      end
    join
    check("apb stall cycles", last_stalls, 1);
    mask_exp = 6'h2A;
    apb_read(cheat_pkg::REG_MASK, 32'h2A);
    apb_read(cheat_pkg::REG_CTRL, 32'h1);
  endtask

  task automatic nmi_hook();
    apb_write(cheat_pkg::REG_CTRL, ctrl_word(3'b111, 3'b010));
    quiet_fetches(2);
    fetch(cheat_pkg::NMI_VEC_LO, cheat_pkg::NMI_HOOK_BYTE, 1'b1);
    fetch(cheat_pkg::NMI_VEC_HI, cheat_pkg::DEFAULT_BYTE, 1'b1);
    fetch(cheat_pkg::IRQ_VEC_LO, cheat_pkg::IRQ_HOOK_BYTE, 1'b0);
    console_cmd(cheat_pkg::CMD_OFFSET, cheat_pkg::CMD_HOOKS_OFF);
    fetch(cheat_pkg::NMI_VEC_LO, cheat_pkg::NMI_HOOK_BYTE, 1'b0);
  endtask

  task automatic holdoff_disable();
    apb_write(cheat_pkg::REG_CTRL, ctrl_word(3'b111, 3'b010));
    quiet_fetches(2);
    fetch(cheat_pkg::NMI_VEC_LO, cheat_pkg::NMI_HOOK_BYTE, 1'b1);
    console_cmd(cheat_pkg::CMD_OFFSET, cheat_pkg::CMD_HOLDOFF);
    quiet_fetches(2);
    fetch(cheat_pkg::NMI_VEC_LO, cheat_pkg::NMI_HOOK_BYTE, 1'b0);
    apb_read(cheat_pkg::REG_STATUS, status_word(1, 0, 0, 0));
    repeat (HOOK_HOLDOFF / 2) @(posedge clk);
    quiet_fetches(2);
    fetch(cheat_pkg::NMI_VEC_LO, cheat_pkg::NMI_HOOK_BYTE, 1'b0);
    // Let the holdoff count run out
    repeat (HOOK_HOLDOFF) @(posedge clk);
    quiet_fetches(2);
    fetch(cheat_pkg::NMI_VEC_LO, cheat_pkg::NMI_HOOK_BYTE, 1'b1);
    console_cmd(cheat_pkg::DISABLE_OFFSET, 8'h01);
    quiet_fetches(2);
    fetch(cheat_pkg::NMI_VEC_LO, cheat_pkg::NMI_HOOK_BYTE, 1'b0);
    apb_read(cheat_pkg::REG_STATUS, status_word(1, 0, 0, 1));
    console_cmd(cheat_pkg::DISABLE_OFFSET, 8'h00);
  endtask

  task automatic vector_autoselect();
    apb_write(cheat_pkg::REG_CTRL, ctrl_word(3'b111, 3'b000));
    // Two cycles per fetch covers two full periods
    repeat ((2 ** USAGE_CNT_W) + 8) fetch(cheat_pkg::IRQ_VEC_HI, cheat_pkg::DEFAULT_BYTE, 1'b0);
    apb_read(cheat_pkg::REG_STATUS, status_word(0, 1, 1, 0));
    apb_write(cheat_pkg::REG_CTRL, ctrl_word(3'b111, 3'b100));
    quiet_fetches(2);
    fetch(cheat_pkg::IRQ_VEC_LO, cheat_pkg::IRQ_HOOK_BYTE, 1'b1);
    fetch(cheat_pkg::IRQ_VEC_HI, cheat_pkg::DEFAULT_BYTE, 1'b1);
  endtask

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Watchdog expired before the tests finished");
    $display("Simulation FAILED");
    $fatal(1, "timeout");
  end

  initial begin
    clk = 1'b0;
    arst_n = 1'b0;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
    paddr = '0;
    pwdata = '0;
    bus_addr = QUIET_ADDR;
    bus_data = '0;
    cmd_wr = 1'b0;
    cycle_start = 1'b0;
    lfsr = 16'd79;
    err_cnt = 0;
    last_stalls = 0;
    mask_exp = '0;
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    arst_n = 1'b1;
    check("pready", pready, 1);
    check("pslverr", pslverr, 0);
    check("cheat_hit", cheat_hit, 0);
    register_access();
    patch_matching();
    enable_control();
    nmi_hook();
    // Autoselect leaves the IRQ choice behind
    holdoff_disable();
    vector_autoselect();
    if (err_cnt == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

//--- flist.f
cheat_pkg.sv
cheat_bus_if.sv
cheat_cfg_if.sv
cheat_apb_regs.sv
cheat_patch_match.sv
hook_autoselect.sv
cheat_bus_out.sv
cheat_top.sv
cheat_tb_sva.sv
cheat_tb.sv

//--- Makefile
# Verilator flow for the cheat engine testbench

VERILATOR  ?= verilator
FLIST      ?= flist.f
TB_TOP     ?= cheat_tb
RTL_TOP    ?= cheat_top
OBJ_DIR    ?= obj_dir
LINT_FLAGS ?= --lint-only --timing --assert
SIM_FLAGS  ?= --binary --timing --assert -Wno-fatal
PASS_MSG   ?= Simulation PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FLIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TB_TOP) -Mdir $(OBJ_DIR) -f $(FLIST)
	@out="$$(./$(OBJ_DIR)/V$(TB_TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
